//--- Makefile
VERILATOR ?= verilator
TOP       ?= exec_mem_stage_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: build run clean

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/alu.sv
module alu (
    input  logic                      alu_src_i,
    input  logic [6:0]                opcode_i,
    input  logic [2:0]                funct3_i,
    input  logic [6:0]                funct7_i,
    input  logic [dbus_pkg::XLEN-1:0] rs1_data_i,
    input  logic [dbus_pkg::XLEN-1:0] rs2_data_i,
    input  logic [dbus_pkg::XLEN-1:0] imm_i,
    output logic [dbus_pkg::XLEN-1:0] result_o,
    output logic [dbus_pkg::XLEN-1:0] mem_addr_o,
    output logic                      is_load_o,
    output logic                      is_store_o,
    output logic                      branch_o
);
    import dbus_pkg::*;
    import rv_isa_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0]    operand_b;
    logic [XLEN-1:0]    arith;
    logic [SHAMT_W-1:0] shamt;

    assign operand_b = alu_src_i ? imm_i : rs2_data_i;
    assign shamt     = operand_b[SHAMT_W-1:0];

    always_comb begin
        case (funct3_i)
            F3_ADD: begin
                // only register ops carry a real funct7
                if (opcode_i == OP_REG && funct7_i == F7_SUB) begin
                    arith = rs1_data_i - operand_b;
                end else begin
                    arith = rs1_data_i + operand_b;
                end
            end
            F3_SLL:  arith = rs1_data_i << shamt;
            F3_XOR:  arith = rs1_data_i ^ operand_b;
            F3_SRL:  arith = rs1_data_i >> shamt; // logical only
            F3_OR:   arith = rs1_data_i | operand_b;
            F3_AND:  arith = rs1_data_i & operand_b;
            default: arith = '0;
        endcase
    end

    always_comb begin
        case (opcode_i)
            OP_REG, OP_IMM: result_o = arith;
            OP_LUI:         result_o = imm_i << 12;
            default:        result_o = '0;
        endcase
    end

    // effective address, independent of operand select
    assign mem_addr_o = rs1_data_i + imm_i;
    assign is_load_o  = (opcode_i == OP_LOAD);
    assign is_store_o = (opcode_i == OP_STORE);

    always_comb begin
        branch_o = 1'b0;
        case (opcode_i)
            OP_BRANCH: begin
                case (funct3_i)
                    F3_BEQ:  branch_o = (rs1_data_i == operand_b);
                    F3_BNE:  branch_o = (rs1_data_i != operand_b);
                    F3_BLTU: branch_o = (rs1_data_i < operand_b);
                    F3_BGEU: branch_o = (rs1_data_i >= operand_b);
                    default: branch_o = 1'b0;
                endcase
            end
            OP_JAL, OP_JALR: branch_o = 1'b1; // jumps always taken
            default:         branch_o = 1'b0;
        endcase
    end

endmodule

//--- logic/dbus_pkg.sv
package dbus_pkg;

    // data word and register width
    localparam int XLEN = 32;

    // bus address width unless the top level overrides it
    localparam int DEF_ADDR_W = 32;

endpackage

//--- logic/exec_mem_stage.sv
module exec_mem_stage #(
    parameter int NUM_REGS = 32,
    parameter int ADDR_W   = dbus_pkg::DEF_ADDR_W
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_i,
    input  logic [6:0]                  opcode_i,
    input  logic [2:0]                  funct3_i,
    input  logic [6:0]                  funct7_i,
    input  logic                        alu_src_i,
    input  logic [dbus_pkg::XLEN-1:0]   imm_i,
    input  logic [$clog2(NUM_REGS)-1:0] rd_i,
    input  logic [$clog2(NUM_REGS)-1:0] rs1_i,
    input  logic [$clog2(NUM_REGS)-1:0] rs2_i,
    input  logic                        reg_write_i,
    input  logic                        mem_to_reg_i,
    input  logic [dbus_pkg::XLEN-1:0]   data_bus_i,
    input  logic                        data_good_i,
    output logic                        branch_o,
    output logic                        busy_o,
    output logic                        data_read_o,
    output logic                        data_write_o,
    output logic [ADDR_W-1:0]           data_adr_o,
    output logic [dbus_pkg::XLEN-1:0]   data_bus_o,
    output logic                        wb_en_o,
    output logic [$clog2(NUM_REGS)-1:0] wb_rd_o,
    output logic [dbus_pkg::XLEN-1:0]   wb_data_o
);
    import dbus_pkg::*;

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mem_addr;
    logic            is_load;
    logic            is_store;

    register_file #(
        .NUM_REGS(NUM_REGS)
    ) u_regfile (
        .clk      (clk),
        .rst      (rst),
        .we_i     (wb_en_o),
        .waddr_i  (wb_rd_o),
        .wdata_i  (wb_data_o),
        .raddr1_i (rs1_i),
        .raddr2_i (rs2_i),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    alu u_alu (
        .alu_src_i  (alu_src_i),
        .opcode_i   (opcode_i),
        .funct3_i   (funct3_i),
        .funct7_i   (funct7_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .imm_i      (imm_i),
        .result_o   (alu_result),
        .mem_addr_o (mem_addr),
        .is_load_o  (is_load),
        .is_store_o (is_store),
        .branch_o   (branch_o)
    );

    load_store_unit #(
        .ADDR_W   (ADDR_W),
        .NUM_REGS (NUM_REGS)
    ) u_lsu (
        .clk          (clk),
        .rst          (rst),
        .issue_i      (issue_i),
        .is_load_i    (is_load),
        .is_store_i   (is_store),
        .mem_addr_i   (mem_addr),
        .store_data_i (rs2_data), // stores always take rs2
        .alu_result_i (alu_result),
        .rd_i         (rd_i),
        .reg_write_i  (reg_write_i),
        .mem_to_reg_i (mem_to_reg_i),
        .data_bus_i   (data_bus_i),
        .data_good_i  (data_good_i),
        .data_read_o  (data_read_o),
        .data_write_o (data_write_o),
        .data_adr_o   (data_adr_o),
        .data_bus_o   (data_bus_o),
        .busy_o       (busy_o),
        .wb_en_o      (wb_en_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

//--- logic/load_store_unit.sv
module load_store_unit #(
    parameter int ADDR_W   = dbus_pkg::DEF_ADDR_W,
    parameter int NUM_REGS = 32
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_i,
    input  logic                        is_load_i,
    input  logic                        is_store_i,
    input  logic [dbus_pkg::XLEN-1:0]   mem_addr_i,
    input  logic [dbus_pkg::XLEN-1:0]   store_data_i,
    input  logic [dbus_pkg::XLEN-1:0]   alu_result_i,
    input  logic [$clog2(NUM_REGS)-1:0] rd_i,
    input  logic                        reg_write_i,
    input  logic                        mem_to_reg_i,
    input  logic [dbus_pkg::XLEN-1:0]   data_bus_i,
    input  logic                        data_good_i,
    output logic                        data_read_o,
    output logic                        data_write_o,
    output logic [ADDR_W-1:0]           data_adr_o,
    output logic [dbus_pkg::XLEN-1:0]   data_bus_o,
    output logic                        busy_o,
    output logic                        wb_en_o,
    output logic [$clog2(NUM_REGS)-1:0] wb_rd_o,
    output logic [dbus_pkg::XLEN-1:0]   wb_data_o
);
    import dbus_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    logic             accept;
    logic             mem_req;
    logic             load_done;
    logic             mem_to_reg_q;
    logic [IDX_W-1:0] rd_q;

    assign accept  = issue_i & ~busy_o;
    assign mem_req = accept & (is_load_i | is_store_i);
    assign busy_o  = data_read_o | data_write_o;

    // request holds until data_good is seen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_read_o  <= 1'b0;
            data_write_o <= 1'b0;
            data_adr_o   <= '0;
            data_bus_o   <= '0;
            mem_to_reg_q <= 1'b0;
        end else if (mem_req) begin
            data_read_o  <= is_load_i;
            data_write_o <= is_store_i;
            data_adr_o   <= mem_addr_i[ADDR_W-1:0]; // truncated to bus width
            if (is_store_i) begin
                data_bus_o <= store_data_i;
            end
            mem_to_reg_q <= is_load_i & mem_to_reg_i & reg_write_i;
        end else if (busy_o && data_good_i) begin
            data_read_o  <= 1'b0;
            data_write_o <= 1'b0;
            mem_to_reg_q <= 1'b0;
        end
    end

    // destination of the outstanding load
    always_ff @(posedge clk) begin
        if (mem_req && is_load_i) begin
            rd_q <= rd_i;
        end
    end

    assign load_done = data_read_o & data_good_i & mem_to_reg_q;

    // single write port, a finishing load takes it
    always_comb begin
        if (load_done) begin
            wb_en_o   = 1'b1;
            wb_rd_o   = rd_q;
            wb_data_o = data_bus_i;
        end else begin
            // a load into a register writes later, at data_good
            wb_en_o   = accept & reg_write_i & ~(is_load_i & mem_to_reg_i);
            wb_rd_o   = rd_i;
            wb_data_o = alu_result_i;
        end
    end

endmodule

//--- logic/register_file.sv
module register_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        we_i,
    input  logic [$clog2(NUM_REGS)-1:0] waddr_i,
    input  logic [dbus_pkg::XLEN-1:0]   wdata_i,
    input  logic [$clog2(NUM_REGS)-1:0] raddr1_i,
    input  logic [$clog2(NUM_REGS)-1:0] raddr2_i,
    output logic [dbus_pkg::XLEN-1:0]   rdata1_o,
    output logic [dbus_pkg::XLEN-1:0]   rdata2_o
);
    import dbus_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational reads, a same-cycle write shows up next cycle
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // alu operations by funct3
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // branch tests, unsigned compares only
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_SUB = 7'b0100000; // add becomes sub

endpackage

//--- tests/exec_mem_assertions.sv
module exec_mem_assertions #(
    parameter int ADDR_W = 32
) (
    input logic              clk,
    input logic              rst,
    input logic              issue_i,
    input logic              busy_i,
    input logic              data_read_i,
    input logic              data_write_i,
    input logic              data_good_i,
    input logic [ADDR_W-1:0] data_adr_i
);
    timeunit 1ns;
    timeprecision 100ps;

    no_issue_while_busy: assert property (@(posedge clk) disable iff (rst)
        busy_i |-> !issue_i) else $error("issue raised while the stage was busy");

    one_direction: assert property (@(posedge clk) disable iff (rst)
        !(data_read_i && data_write_i)) else $error("read and write requested together");

    // pending request keeps its address
    adr_stable: assert property (@(posedge clk) disable iff (rst)
        (busy_i && !data_good_i) |=> (busy_i && $stable(data_adr_i)))
        else $error("request dropped or address changed before data_good");

    busy_falls_on_good: assert property (@(posedge clk) disable iff (rst)
        $fell(busy_i) |-> $past(data_good_i)) else $error("busy fell without data_good");

endmodule

bind load_store_unit exec_mem_assertions #(.ADDR_W(ADDR_W)) u_assertions (
    .clk          (clk),
    .rst          (rst),
    .issue_i      (issue_i),
    .busy_i       (busy_o),
    .data_read_i  (data_read_o),
    .data_write_i (data_write_o),
    .data_good_i  (data_good_i),
    .data_adr_i   (data_adr_o)
);

//--- tests/exec_mem_stage_tb.sv
module exec_mem_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dbus_pkg::*;
    import rv_isa_pkg::*;

    localparam int NUM_REGS = 32;
    localparam int ADDR_W   = DEF_ADDR_W;
    localparam int IDX_W    = $clog2(NUM_REGS);
    localparam int N_INSTR  = 400;
    localparam int TIMEOUT  = N_INSTR * 5 + 20;

    logic              clk;
    logic              rst;
    logic              issue_i;
    logic [6:0]        opcode_i;
    logic [2:0]        funct3_i;
    logic [6:0]        funct7_i;
    logic              alu_src_i;
    logic [XLEN-1:0]   imm_i;
    logic [IDX_W-1:0]  rd_i;
    logic [IDX_W-1:0]  rs1_i;
    logic [IDX_W-1:0]  rs2_i;
    logic              reg_write_i;
    logic              mem_to_reg_i;
    logic [XLEN-1:0]   data_bus_i;
    logic              data_good_i;
    logic              branch_o;
    logic              busy_o;
    logic              data_read_o;
    logic              data_write_o;
    logic [ADDR_W-1:0] data_adr_o;
    logic [XLEN-1:0]   data_bus_o;
    logic              wb_en_o;
    logic [IDX_W-1:0]  wb_rd_o;
    logic [XLEN-1:0]   wb_data_o;

    logic [31:0]       lfsr;
    logic [XLEN-1:0]   mem [16]; // responder memory
    int                cycles;
    int                issued;

    tb_clock clkgen (.clk_o(clk));

    exec_mem_stage #(
        .NUM_REGS (NUM_REGS),
        .ADDR_W   (ADDR_W)
    ) uut (.*);

    stage_checker #(
        .NUM_REGS (NUM_REGS),
        .ADDR_W   (ADDR_W)
    ) chk (
        .branch_i (branch_o),
        .busy_i   (busy_o),
        .data_read_i  (data_read_o),
        .data_write_i (data_write_o),
        .data_adr_i   (data_adr_o),
        .data_bus_i   (data_bus_o),
        .wb_en_i  (wb_en_o),
        .wb_rd_i  (wb_rd_o),
        .wb_data_i (wb_data_o),
        .data_good_i (data_good_i),
        .*
    );

    function automatic logic next_random_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h80200003; // galois taps 32,22,2,1
        end
        return b;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_random_bit()};
        end
    endtask

    function automatic logic [2:0] pick_alu_funct3(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd6: return F3_ADD;
            3'd1:       return F3_SLL;
            3'd2, 3'd7: return F3_XOR;
            3'd3:       return F3_SRL;
            3'd4:       return F3_OR;
            default:    return F3_AND;
        endcase
    endfunction

    task automatic run_instruction();
        logic [31:0] r;
        logic [31:0] kind;
        rand_bits(3, kind);
        rand_bits(5, r);
        rd_i = r[IDX_W-1:0];
        rand_bits(5, r);
        rs1_i = r[IDX_W-1:0];
        rand_bits(5, r);
        rs2_i        = r[IDX_W-1:0];
        funct3_i     = F3_ADD;
        funct7_i     = '0;
        alu_src_i    = 1'b1;
        imm_i        = '0;
        reg_write_i  = 1'b0;
        mem_to_reg_i = 1'b0;
        case (kind[2:0])
            3'd0, 3'd1: begin
                opcode_i    = OP_REG;
                alu_src_i   = 1'b0;
                reg_write_i = 1'b1;
                rand_bits(4, r);
                funct3_i = pick_alu_funct3(r[2:0]);
                if (funct3_i == F3_ADD && r[3]) begin
                    funct7_i = F7_SUB;
                end
            end
            3'd2: begin
                opcode_i    = OP_IMM;
                reg_write_i = 1'b1;
                rand_bits(4, r);
                funct3_i = pick_alu_funct3(r[2:0]);
                funct7_i = r[3] ? F7_SUB : '0; // no subtract for immediates
                rand_bits(12, r);
                imm_i = {{20{r[11]}}, r[11:0]};
            end
            3'd3: begin
                opcode_i    = OP_LUI;
                reg_write_i = 1'b1;
                rand_bits(20, r);
                imm_i = r;
            end
            3'd4, 3'd5: begin
                opcode_i = (kind[2:0] == 3'd4) ? OP_LOAD : OP_STORE;
                reg_write_i  = (opcode_i == OP_LOAD);
                mem_to_reg_i = (opcode_i == OP_LOAD);
                rand_bits(4, r);
                imm_i = {26'd0, r[3:0], 2'b00}; // word aligned offsets
            end
            3'd6: begin
                opcode_i  = OP_BRANCH;
                alu_src_i = 1'b0;
                rand_bits(3, r);
                case (r[1:0])
                    2'd0:    funct3_i = F3_BEQ;
                    2'd1:    funct3_i = F3_BNE;
                    2'd2:    funct3_i = F3_BLTU;
                    default: funct3_i = F3_BGEU;
                endcase
                if (r[2]) begin
                    rs2_i = rs1_i; // force equal operands now and then
                end
            end
            default: begin
                rand_bits(2, r);
                opcode_i    = r[0] ? OP_JAL : OP_JALR;
                reg_write_i = r[1];
            end
        endcase
        issue_i = 1'b1;
        issued++;
        @(negedge clk);
        issue_i = 1'b0;
        if (opcode_i == OP_LOAD || opcode_i == OP_STORE) begin
            rand_bits(2, r);
            repeat (int'(r[1:0])) @(negedge clk);
            if (data_write_o) begin
                mem[data_adr_o[5:2]] = data_bus_o;
            end
            data_bus_i  = mem[data_adr_o[5:2]];
            data_good_i = 1'b1;
            @(negedge clk);
            data_good_i = 1'b0;
            data_bus_i  = '0;
            while (busy_o) begin
                @(negedge clk);
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        lfsr         = 32'h6adcfb1e;
        cycles       = 0;
        issued       = 0;
        rst          = 1'b1;
        issue_i      = 1'b0;
        opcode_i     = '0;
        funct3_i     = '0;
        funct7_i     = '0;
        alu_src_i    = 1'b0;
        imm_i        = '0;
        rd_i         = '0;
        rs1_i        = '0;
        rs2_i        = '0;
        reg_write_i  = 1'b0;
        mem_to_reg_i = 1'b0;
        data_bus_i   = '0;
        data_good_i  = 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = (i * 32'h9e3779b9) ^ 32'h5a5a0000;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int n = 0; n < N_INSTR; n++) begin
            run_instruction();
        end
        @(negedge clk);
        $display("summary: %0d instructions issued, %0d errors", issued, chk.errors);
        if (chk.errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/stage_checker.sv
module stage_checker #(
    parameter int NUM_REGS = 32,
    parameter int ADDR_W   = 32
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        issue_i,
    input logic [6:0]                  opcode_i,
    input logic [2:0]                  funct3_i,
    input logic [6:0]                  funct7_i,
    input logic                        alu_src_i,
    input logic [dbus_pkg::XLEN-1:0]   imm_i,
    input logic [$clog2(NUM_REGS)-1:0] rd_i,
    input logic [$clog2(NUM_REGS)-1:0] rs1_i,
    input logic [$clog2(NUM_REGS)-1:0] rs2_i,
    input logic                        reg_write_i,
    input logic                        data_good_i,
    input logic                        branch_i,
    input logic                        busy_i,
    input logic                        data_read_i,
    input logic                        data_write_i,
    input logic [ADDR_W-1:0]           data_adr_i,
    input logic [dbus_pkg::XLEN-1:0]   data_bus_i,
    input logic                        wb_en_i,
    input logic [$clog2(NUM_REGS)-1:0] wb_rd_i,
    input logic [dbus_pkg::XLEN-1:0]   wb_data_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import dbus_pkg::*;
    import rv_isa_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    int                errors;
    logic [XLEN-1:0]   regs [NUM_REGS];
    logic [XLEN-1:0]   mem [16];
    logic              pend;
    logic              p_load;
    logic [XLEN-1:0]   p_addr;
    logic [XLEN-1:0]   p_data;
    logic [IDX_W-1:0]  p_rd;
    logic              after_reset;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   exp_res;

    initial begin
        errors = 0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = (i * 32'h9e3779b9) ^ 32'h5a5a0000; // same fill as responder
        end
    end

    task automatic check_val(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    function automatic logic [XLEN-1:0] model_result(input logic [6:0] op,
            input logic [2:0] f3, input logic [6:0] f7, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm);
        logic [XLEN-1:0] r;
        r = '0;
        if (op == OP_REG || op == OP_IMM) begin
            case (f3)
                F3_ADD:  r = (op == OP_REG && f7 == F7_SUB) ? a - b : a + b;
                F3_SLL:  r = a << b[4:0];
                F3_XOR:  r = a ^ b;
                F3_SRL:  r = a >> b[4:0];
                F3_OR:   r = a | b;
                F3_AND:  r = a & b;
                default: r = '0;
            endcase
        end else if (op == OP_LUI) begin
            r = {imm[19:0], 12'h000};
        end
        return r;
    endfunction

    function automatic logic model_branch(input logic [6:0] op, input logic [2:0] f3,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        if (op == OP_JAL || op == OP_JALR) begin
            return 1'b1;
        end
        if (op != OP_BRANCH) begin
            return 1'b0;
        end
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] = '0;
            end
            pend        = 1'b0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                check_val("data_read_o", '0, XLEN'(data_read_i));
                check_val("data_write_o", '0, XLEN'(data_write_i));
                check_val("data_adr_o", '0, XLEN'(data_adr_i));
                check_val("data_bus_o", '0, data_bus_i);
                check_val("wb_en_o", '0, XLEN'(wb_en_i));
                check_val("branch_o", '0, XLEN'(branch_i));
                after_reset = 1'b0;
            end
            if (pend) begin
                check_val("busy_o", 1, XLEN'(busy_i));
                check_val("data_read_o", XLEN'(p_load), XLEN'(data_read_i));
                check_val("data_write_o", XLEN'(!p_load), XLEN'(data_write_i));
                check_val("data_adr_o", p_addr, XLEN'(data_adr_i));
                if (!p_load) begin
                    check_val("data_bus_o", p_data, data_bus_i);
                end
                if (data_good_i) begin
                    if (p_load) begin
                        check_val("wb_en_o", 1, XLEN'(wb_en_i));
                        check_val("wb_rd_o", XLEN'(p_rd), XLEN'(wb_rd_i));
                        check_val("wb_data_o", mem[p_addr[5:2]], wb_data_i);
                        if (p_rd != '0) begin
                            regs[p_rd] = mem[p_addr[5:2]];
                        end
                    end else begin
                        check_val("wb_en_o", 0, XLEN'(wb_en_i));
                        mem[p_addr[5:2]] = p_data;
                    end
                    pend = 1'b0;
                end else begin
                    check_val("wb_en_o", 0, XLEN'(wb_en_i)); // nothing early
                end
            end else begin
                check_val("busy_o", 0, XLEN'(busy_i));
                if (issue_i) begin
                    op_a    = regs[rs1_i];
                    op_b    = alu_src_i ? imm_i : regs[rs2_i];
                    exp_res = model_result(opcode_i, funct3_i, funct7_i, op_a, op_b, imm_i);
                    check_val("branch_o", XLEN'(model_branch(opcode_i, funct3_i, op_a, op_b)),
                              XLEN'(branch_i));
                    if (opcode_i == OP_LOAD || opcode_i == OP_STORE) begin
                        check_val("wb_en_o", 0, XLEN'(wb_en_i));
                        pend   = 1'b1;
                        p_load = (opcode_i == OP_LOAD);
                        p_addr = op_a + imm_i;
                        p_data = regs[rs2_i];
                        p_rd   = rd_i;
                    end else begin
                        check_val("wb_en_o", XLEN'(reg_write_i), XLEN'(wb_en_i));
                        if (reg_write_i) begin
                            check_val("wb_rd_o", XLEN'(rd_i), XLEN'(wb_rd_i));
                            check_val("wb_data_o", exp_res, wb_data_i);
                            if (rd_i != '0) begin
                                regs[rd_i] = exp_res; // x0 stays zero
                            end
                        end
                    end
                end else begin
                    check_val("wb_en_o", 0, XLEN'(wb_en_i)); // idle, no write
                end
            end
        end
    end

endmodule

//--- tests/tb_clock.sv
module tb_clock (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
    end

    always #50 clk_o = ~clk_o; // 100 ns period

endmodule

//--- verilog.f
logic/rv_isa_pkg.sv
logic/dbus_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/load_store_unit.sv
logic/exec_mem_stage.sv
tests/tb_clock.sv
tests/exec_mem_assertions.sv
tests/stage_checker.sv
tests/exec_mem_stage_tb.sv
